// File: sysCtl.f
+incdir+include
logic/sysCtlPkg.sv
logic/busCycleMonitor.sv
logic/regionDecode.sv
logic/devDecode.sv
logic/fastRamCtl.sv
logic/ioCycleSeq.sv
logic/sysCtl.sv
tests/sysCtlChecker.sv
tests/sysCtlTb.sv

// File: run.sh
#!/usr/bin/env bash
# Build with Verilator, run, and pass only if the testbench reports a pass
cd "$(dirname "$0")" \
  && verilator --binary --timing --assert -Wno-fatal --top-module sysCtlTb -f sysCtl.f \
  && ./obj_dir/VsysCtlTb | tee /dev/stderr | grep -qF '*** TEST PASSED ***' \
  && echo "Simulation passed" \
  || { echo "Simulation failed"; exit 1; }

// File: tests/sysCtlTb.sv
`default_nettype none

`include "sysCtl_defs.svh"

module sysCtlTb;

  localparam int NumCycles = 400;
  // An MMIO cycle runs into berr well inside 80 clocks
  localparam int TimeoutCycles = NumCycles * 80;

  logic CPU_CLK, nRST, nAS, nDS, rnW;
  sysCtlPkg::siz_t siz;
  sysCtlPkg::fc_t fc;
  sysCtlPkg::addr_t addr;
  logic nRomSel, nDevSel, nMmioSel, nFpuSel, nIackSel, nDuartSel, nTmrSel;
  logic nAtaSel, nI2cSel, nIntcSel, nFramSel, nFramRd, nFramWr;
  logic sterm, ci, berr, nIoRd, nIoWr;
  sysCtlPkg::dramSel_t nDramSel;
  sysCtlPkg::byteEn_t nFramBe;
  sysCtlPkg::dsack_t dsack;
  int errCount, checkCount, clkCount;
  logic [31:0] lfsr = 32'h4f819dc5;

  sysCtl dut0 (.*);
  sysCtlChecker check0 (.*);

  initial begin
    CPU_CLK = 1'b0;
    forever #50 CPU_CLK = ~CPU_CLK;
  end

  // Galois LFSR, x^32 + x^22 + x^2 + x + 1
  function automatic logic [31:0] lfsrNext(input logic [31:0] s);
    return s[0] ? ((s >> 1) ^ 32'h80200003) : (s >> 1);
  endfunction

  // One step per bit
  task automatic takeBits(input int n, output logic [31:0] bits);
    bits = '0;
    for (int i = 0; i < n; i++) begin
      lfsr = lfsrNext(lfsr);
      bits = {bits[30:0], lfsr[0]};
    end
  endtask

  task automatic runBusCycle(input int n);
    logic [31:0] rnd, region, rw, sz, fcPick, devPick, devRnd;
    logic [15:0] off;
    sysCtlPkg::addr_t a;
    sysCtlPkg::fc_t fcSel;
    int limit, held;
    logic done;
    takeBits(32, rnd);
    takeBits(3, region);
    takeBits(1, rw);
    takeBits(2, sz);
    takeBits(3, fcPick);
    takeBits(3, devPick);
    takeBits(16, devRnd);
    // Overlay window, then one plain bank 0 access
    if (n < 4) begin
      region = 32'd3;
      rnd[29:28] = 2'b00;
      fcPick[2] = 1'b0;
      if (n < 3)
        rw = 32'd1;
    end
    case (devPick[2:0])
      3'd0: off = `SYSCTL_DEV_DUART;
      3'd1: off = `SYSCTL_DEV_TMR;
      3'd2: off = `SYSCTL_DEV_ATA;
      3'd3: off = `SYSCTL_DEV_I2C;
      3'd4: off = `SYSCTL_DEV_INTC;
      default: off = devRnd[15:0];
    endcase
    case (region[2:0])
      3'd0: a = {`SYSCTL_ROM_TAG, rnd[19:0]};
      3'd1: a = {`SYSCTL_DEV_TAG, off, rnd[3:0]};
      3'd2: a = {`SYSCTL_MMIO_TAG, rnd[29:0]};
      3'd4: a = {`SYSCTL_FRAM_TAG, rnd[21:0]};
      3'd5: a = {rnd[31:20], `SYSCTL_FPU_ID, rnd[12:0]};
      3'd6: a = {rnd[31:20], `SYSCTL_IACK_TYPE, rnd[15:0]};
      default: a = {`SYSCTL_DRAM_TAG, rnd[29:0]};
    endcase
    // FPU and IACK live in CPU space
    // Upper pick bit moves other cycles out of normal space
    fcSel = (region[2:0] == 3'd5 || region[2:0] == 3'd6) ? 3'd7 :
      {fcPick[1:0], fcPick[0] ^ ~fcPick[2]};
    // MMIO runs into berr, ROM and devices may wait on the sequencer
    limit = (region[2:0] == 3'd2) ? 0 : (region[2:0] <= 3'd1) ? 10 : 3;
    @(posedge CPU_CLK);
    addr <= a;
    fc <= fcSel;
    rnW <= rw[0];
    siz <= sz[1:0];
    nAS <= 1'b0;
    // Data strobe a cycle behind the address strobe
    @(posedge CPU_CLK);
    nDS <= 1'b0;
    held = 0;
    done = 1'b0;
    while (!done) begin
      @(negedge CPU_CLK);
      held++;
      done = dsack != 2'b00 || sterm || berr || (limit != 0 && held >= limit);
    end
    @(posedge CPU_CLK);
    nAS <= 1'b1;
    nDS <= 1'b1;
  endtask

  initial begin
    nRST <= 1'b0;
    nAS <= 1'b1;
    nDS <= 1'b1;
    rnW <= 1'b1;
    siz <= '0;
    fc <= '0;
    addr <= '0;
    repeat (16) @(posedge CPU_CLK);
    nRST <= 1'b1;
    for (int n = 0; n < NumCycles; n++)
      runBusCycle(n);
    repeat (4) @(posedge CPU_CLK);
    $display("Checks: %0d compared, %0d errors", checkCount, errCount);
    if (errCount == 0)
      $display("*** TEST PASSED ***");
    else
      $display("*** TEST FAILED ***");
    $finish;
  end

  // Hang guard
  always @(posedge CPU_CLK) begin
    clkCount <= clkCount + 1;
    if (clkCount == TimeoutCycles) begin
      $display("Timeout: test still running after %0d clock cycles", TimeoutCycles);
      $display("Checks: %0d compared, %0d errors", checkCount, errCount);
      $display("*** TEST FAILED ***");
      $finish;
    end
  end

endmodule

`default_nettype wire

// File: tests/sysCtlChecker.sv
`default_nettype none

`include "sysCtl_defs.svh"

module sysCtlChecker (
  input  wire                      CPU_CLK,
  input  wire                      nRST,
  input  wire                      nAS,
  input  wire                      nDS,
  input  wire                      rnW,
  input  wire sysCtlPkg::siz_t     siz,
  input  wire sysCtlPkg::fc_t      fc,
  input  wire sysCtlPkg::addr_t    addr,
  input  wire                      nRomSel, nDevSel, nMmioSel, nFpuSel, nIackSel,
  input  wire sysCtlPkg::dramSel_t nDramSel,
  input  wire                      nDuartSel, nTmrSel, nAtaSel, nI2cSel, nIntcSel,
  input  wire                      nFramSel, nFramRd, nFramWr,
  input  wire sysCtlPkg::byteEn_t  nFramBe,
  input  wire                      sterm, ci, berr, nIoRd, nIoWr,
  input  wire sysCtlPkg::dsack_t   dsack,
  output int                       errCount,
  output int                       checkCount
);

  localparam int SeqIdle = 0;
  localparam int SeqWait = 1;
  localparam int SeqHold = 2;
  localparam int SeqRecover = 3;

  // Bus history
  logic asPrev;
  int doneCycles, lowRun;
  // Sequencer model
  int seqMode, seqCnt;
  logic seqRom, seqTmr, seqTmrRd, strobe;
  logic [1:0] ackReg;
  // Expected outputs
  logic overlay, normal, cpu, devSpace, fram, romRd, duart, tmr, i2c, known, ioStrobe;
  logic [15:0] off;
  logic [3:0] banks, lanes;
  logic [14:0] expSel;
  logic [5:0] expFram;
  logic [4:0] expBus;
  logic [1:0] expAck;

  always_comb begin
    overlay = doneCycles < `SYSCTL_BOOT_CYCLES;
    // Data and program spaces, user or supervisor
    normal = !nAS && (fc == 3'd1 || fc == 3'd2 || fc == 3'd5 || fc == 3'd6);
    cpu = !nAS && fc == 3'd7;
    off = addr[19:4];
    devSpace = normal && addr[31:20] == `SYSCTL_DEV_TAG;
    fram = normal && addr[31:22] == `SYSCTL_FRAM_TAG;
    // Bank 0 is hidden behind ROM during the overlay
    banks = 4'b0000;
    if (normal && addr[31:30] == `SYSCTL_DRAM_TAG && !(overlay && addr[29:28] == 2'd0))
      banks[addr[29:28]] = 1'b1;
    romRd = normal && rnW && (addr[31:20] == `SYSCTL_ROM_TAG ||
      (overlay && addr[31:28] == {`SYSCTL_DRAM_TAG, 2'b00}));
    duart = devSpace && off == `SYSCTL_DEV_DUART;
    tmr = devSpace && off == `SYSCTL_DEV_TMR;
    i2c = devSpace && off == `SYSCTL_DEV_I2C;
    known = duart || tmr || i2c || off == `SYSCTL_DEV_ATA || off == `SYSCTL_DEV_INTC;
    // Lane 0 is the MSB, take siz bytes then shift to the offset
    lanes = ~(4'hf >> ((siz == 2'd0) ? 3'd4 : {1'b0, siz})) >> addr[1:0];
    ioStrobe = (devSpace && !(tmr && rnW)) || strobe;
    expSel = ~{romRd, devSpace && !known, normal && addr[31:30] == `SYSCTL_MMIO_TAG, banks,
      cpu && addr[19:13] == `SYSCTL_FPU_ID, cpu && addr[19:16] == `SYSCTL_IACK_TYPE,
      duart, tmr, devSpace && off == `SYSCTL_DEV_ATA, i2c && !nDS,
      devSpace && off == `SYSCTL_DEV_INTC, fram};
    expFram = {!(fram && rnW), !(fram && !rnW), fram ? (rnW ? 4'h0 : ~lanes) : 4'hf};
    expBus = {fram, overlay || devSpace, lowRun >= `SYSCTL_BERR_LIMIT,
      !(ioStrobe && !nDS && rnW), !(ioStrobe && !nDS && !rnW)};
    expAck = nDS ? 2'b00 : ackReg;
  end

  always @(posedge CPU_CLK or negedge nRST) begin
    if (!nRST) begin
      asPrev <= 1'b1;
      doneCycles <= 0;
      lowRun <= 0;
      seqMode <= SeqIdle;
      seqCnt <= 0;
      ackReg <= 2'b00;
      strobe <= 1'b0;
    end else begin
      asPrev <= nAS;
      // Completed cycle seen as nAS going high
      if (nAS && !asPrev && doneCycles < `SYSCTL_BOOT_CYCLES)
        doneCycles <= doneCycles + 1;
      lowRun <= nAS ? 0 : lowRun + 1;
      case (seqMode)
        SeqIdle: begin
          seqRom <= romRd;
          seqTmr <= tmr;
          seqTmrRd <= tmr && rnW;
          if (romRd || (duart && !rnW)) begin
            seqMode <= SeqWait;
            seqCnt <= 1;
          end else if (duart) begin
            ackReg <= `SYSCTL_PORT8;
            seqMode <= SeqHold;
          end else if (tmr && (rnW || !nDS)) begin
            seqMode <= SeqWait;
            seqCnt <= rnW ? 4 : 3;
          end
        end
        SeqWait: begin
          // Delayed timer strobe, one edge after the start
          if (seqTmrRd && seqCnt == 4)
            strobe <= 1'b1;
          if (seqCnt == 1) begin
            ackReg <= seqRom ? `SYSCTL_PORT16 : `SYSCTL_PORT8;
            seqMode <= SeqHold;
          end
          seqCnt <= seqCnt - 1;
        end
        SeqHold: begin
          if (nDS) begin
            ackReg <= 2'b00;
            strobe <= 1'b0;
            seqMode <= seqTmr ? SeqRecover : SeqIdle;
            seqCnt <= 2;
          end
        end
        default: begin
          // Timer recovery
          if (seqCnt == 1)
            seqMode <= SeqIdle;
          seqCnt <= seqCnt - 1;
        end
      endcase
    end
  end

  task automatic compare(input string what, input logic [15:0] got, input logic [15:0] exp);
    checkCount++;
    if (got !== exp) begin
      errCount++;
      $display("ERR %0t: %s got %h, expected %h", $time, what, got, exp);
    end
  endtask

  // Outputs settled mid-cycle
  always @(negedge CPU_CLK) begin
    if (nRST) begin
      compare("selects", {nRomSel, nDevSel, nMmioSel, nDramSel, nFpuSel, nIackSel,
        nDuartSel, nTmrSel, nAtaSel, nI2cSel, nIntcSel, nFramSel}, expSel);
      compare("fast RAM", {nFramRd, nFramWr, nFramBe}, expFram);
      compare("bus control", {sterm, ci, berr, nIoRd, nIoWr}, expBus);
      compare("dsack", dsack, expAck);
    end
  end

endmodule

`default_nettype wire

// File: logic/sysCtl.sv
`default_nettype none

module sysCtl (
  input  wire                      CPU_CLK,
  input  wire                      nRST,
  input  wire                      nAS,
  input  wire                      nDS,
  input  wire                      rnW,
  input  wire sysCtlPkg::siz_t     siz,
  input  wire sysCtlPkg::fc_t      fc,
  input  wire sysCtlPkg::addr_t    addr,
  // Selects
  output wire                      nRomSel,
  output wire                      nDevSel,
  output wire                      nMmioSel,
  output wire sysCtlPkg::dramSel_t nDramSel,
  output wire                      nFpuSel,
  output wire                      nIackSel,
  output wire                      nDuartSel,
  output wire                      nTmrSel,
  output wire                      nAtaSel,
  output wire                      nI2cSel,
  output wire                      nIntcSel,
  output wire                      nFramSel,
  // Fast RAM
  output wire                      nFramRd,
  output wire                      nFramWr,
  output wire sysCtlPkg::byteEn_t  nFramBe,
  // Bus control
  output wire                      sterm,
  output wire                      ci,
  output wire                      berr,
  output wire sysCtlPkg::dsack_t   dsack,
  output wire                      nIoRd,
  output wire                      nIoWr
);

  wire resetVecFetch;
  // Raw device-space hit before sub-decode
  wire nDevSpace;

  busCycleMonitor monitor0 (.CPU_CLK, .nRST, .nAS, .resetVecFetch, .berr);

  regionDecode region0 (.nAS, .rnW, .fc, .addr, .resetVecFetch, .nRomSel, .nDevSpace,
    .nMmioSel, .nDramSel, .nFpuSel, .nIackSel, .ci);

  devDecode dev0 (.nDevSpace, .nDS, .addr, .nDuartSel, .nTmrSel, .nAtaSel, .nI2cSel,
    .nIntcSel, .nDevSel);

  fastRamCtl fram0 (.nAS, .fc, .addr, .rnW, .siz, .sterm, .nFramSel, .nFramRd, .nFramWr,
    .nFramBe);

  // Only ROM, DUART and timer are sequenced here
  ioCycleSeq seq0 (.CPU_CLK, .nRST, .nDS, .rnW, .nRomSel, .nDuartSel, .nTmrSel,
    .nDevSpace, .dsack, .nIoRd, .nIoWr);

endmodule

`default_nettype wire

// File: logic/ioCycleSeq.sv
`default_nettype none

`include "sysCtl_defs.svh"

module ioCycleSeq (
  input  wire                CPU_CLK,
  input  wire                nRST,
  input  wire                nDS,
  input  wire                rnW,
  input  wire                nRomSel,
  input  wire                nDuartSel,
  input  wire                nTmrSel,
  input  wire                nDevSpace,
  output sysCtlPkg::dsack_t  dsack,
  output logic               nIoRd,
  output logic               nIoWr
);

  sysCtlPkg::ioState_t state;
  sysCtlPkg::dsack_t dsackReg;
  logic strobeDly;
  logic strobeDlyNeeded;
  logic ioStrobe;

  // Timer reads need address setup before the strobe
  assign strobeDlyNeeded = !nTmrSel && rnW;

  always_ff @(posedge CPU_CLK or negedge nRST) begin
    if (!nRST) begin
      state <= sysCtlPkg::Idle;
      dsackReg <= 2'b00;
      strobeDly <= 1'b0;
    end else begin
      case (state)
        sysCtlPkg::Idle: begin
          // ROM: one wait state for its access time
          if (!nRomSel)
            state <= sysCtlPkg::WordWait;
          // DUART read terminates straight away
          else if (!nDuartSel && rnW) begin
            dsackReg <= `SYSCTL_PORT8;
            state <= sysCtlPkg::Finish;
          end
          // DUART write: one wait state
          else if (!nDuartSel && !rnW)
            state <= sysCtlPkg::ByteWait;
          // Timer read: strobe goes out a cycle late
          else if (!nTmrSel && rnW)
            state <= sysCtlPkg::TmrRd1;
          // Timer write waits for data strobe
          else if (!nTmrSel && !rnW && !nDS)
            state <= sysCtlPkg::TmrRw2;
        end
        sysCtlPkg::ByteWait: begin
          dsackReg <= `SYSCTL_PORT8;
          state <= sysCtlPkg::Finish;
        end
        sysCtlPkg::WordWait: begin
          dsackReg <= `SYSCTL_PORT16;
          state <= sysCtlPkg::Finish;
        end
        sysCtlPkg::TmrRd1: begin
          strobeDly <= 1'b1;
          state <= sysCtlPkg::TmrRw2;
        end
        // Strobe pulse width
        sysCtlPkg::TmrRw2:
          state <= sysCtlPkg::TmrRw3;
        sysCtlPkg::TmrRw3:
          state <= sysCtlPkg::TmrRw4;
        sysCtlPkg::TmrRw4: begin
          dsackReg <= `SYSCTL_PORT8;
          state <= sysCtlPkg::TmrRec1;
        end
        // Hold until the CPU lets go, then recover
        sysCtlPkg::TmrRec1: begin
          if (nDS) begin
            strobeDly <= 1'b0;
            dsackReg <= 2'b00;
            state <= sysCtlPkg::TmrRec2;
          end
        end
        sysCtlPkg::TmrRec2:
          state <= sysCtlPkg::TmrRec3;
        // Recovery for back-to-back timer accesses
        sysCtlPkg::TmrRec3:
          state <= sysCtlPkg::Idle;
        sysCtlPkg::Finish: begin
          if (nDS) begin
            strobeDly <= 1'b0;
            dsackReg <= 2'b00;
            state <= sysCtlPkg::Idle;
          end
        end
        default:
          state <= sysCtlPkg::Idle;
      endcase
    end
  end

  // Drops as soon as the CPU releases nDS
  assign dsack = dsackReg & {2{!nDS}};

  // External devices get the strobe right away
  assign ioStrobe = (!nDevSpace && !strobeDlyNeeded) || strobeDly;
  assign nIoRd = !(ioStrobe && !nDS && rnW);
  assign nIoWr = !(ioStrobe && !nDS && !rnW);

  noAckWithoutDs: assert property (@(posedge CPU_CLK) disable iff (!nRST)
    nDS |-> (dsack == 2'b00));

endmodule

`default_nettype wire

// File: logic/fastRamCtl.sv
`default_nettype none

`include "sysCtl_defs.svh"

module fastRamCtl (
  input  wire                   nAS,
  input  wire sysCtlPkg::fc_t   fc,
  input  wire sysCtlPkg::addr_t addr,
  input  wire                   rnW,
  input  wire sysCtlPkg::siz_t  siz,
  output logic                  sterm,
  output logic                  nFramSel,
  output logic                  nFramRd,
  output logic                  nFramWr,
  output sysCtlPkg::byteEn_t    nFramBe
);

  logic framHit;
  logic [2:0] span;
  sysCtlPkg::byteEn_t writeBe;

  // Normal space only
  assign framHit = !nAS && (fc[1] ^ fc[0]) && (addr[31:22] == `SYSCTL_FRAM_TAG);

  // Bytes in the transfer, siz 0 is a long word
  assign span = (siz == 2'd0) ? 3'd4 : {1'b0, siz};

  // Write lanes per the 68030 size/offset table
  // Start at the offset, clipped at lane 3
  always_comb begin
    writeBe = 4'b1111;
    for (int lane = 0; lane < 4; lane++) begin
      if (lane >= addr[1:0] && lane < addr[1:0] + span)
        writeBe[3 - lane] = 1'b0;
    end
  end

  // Reads always take the full long word
  always_comb begin
    if (!framHit)
      nFramBe = 4'b1111;
    else if (rnW)
      nFramBe = 4'b0000;
    else
      nFramBe = writeBe;
  end

  assign nFramRd = !(framHit && rnW);
  assign nFramWr = !(framHit && !rnW);

  // Zero-wait synchronous termination, fast RAM is the only STERM source
  assign sterm = framHit;
  assign nFramSel = !framHit;

endmodule

`default_nettype wire

// File: logic/devDecode.sv
`default_nettype none

`include "sysCtl_defs.svh"

module devDecode (
  input  wire                   nDevSpace,
  input  wire                   nDS,
  input  wire sysCtlPkg::addr_t addr,
  output logic                  nDuartSel,
  output logic                  nTmrSel,
  output logic                  nAtaSel,
  output logic                  nI2cSel,
  output logic                  nIntcSel,
  output logic                  nDevSel
);

  logic [15:0] devOffset;
  logic duartHit;
  logic tmrHit;
  logic ataHit;
  logic i2cHit;
  logic intcHit;

  // 16-byte register windows
  assign devOffset = addr[19:4];

  assign duartHit = !nDevSpace && (devOffset == `SYSCTL_DEV_DUART);
  assign tmrHit = !nDevSpace && (devOffset == `SYSCTL_DEV_TMR);
  assign ataHit = !nDevSpace && (devOffset == `SYSCTL_DEV_ATA);
  assign i2cHit = !nDevSpace && (devOffset == `SYSCTL_DEV_I2C);
  // Top of device space
  assign intcHit = !nDevSpace && (devOffset == `SYSCTL_DEV_INTC);

  assign nDuartSel = !duartHit;
  assign nTmrSel = !tmrHit;
  assign nAtaSel = !ataHit;
  assign nIntcSel = !intcHit;

  // I2C chip select waits for nDS
  // Keeps the controller in 68000 interface mode at power-up
  assign nI2cSel = !(i2cHit && !nDS);

  // Whatever is left goes to the external decoder
  assign nDevSel = !(!nDevSpace && !(duartHit || tmrHit || ataHit || i2cHit || intcHit));

endmodule

`default_nettype wire

// File: logic/regionDecode.sv
`default_nettype none

`include "sysCtl_defs.svh"

module regionDecode (
  input  wire                     nAS,
  input  wire                     rnW,
  input  wire sysCtlPkg::fc_t     fc,
  input  wire sysCtlPkg::addr_t   addr,
  input  wire                     resetVecFetch,
  output logic                    nRomSel,
  output logic                    nDevSpace,
  output logic                    nMmioSel,
  output sysCtlPkg::dramSel_t     nDramSel,
  output logic                    nFpuSel,
  output logic                    nIackSel,
  output logic                    ci
);

  logic spaceNormal;
  logic spaceCpu;
  logic normalCycle;
  logic cpuCycle;
  logic dramHit;
  logic overlayHit;
  logic romHit;
  sysCtlPkg::dramSel_t dramOneHot;

  // User/supervisor data or program: FC1 differs from FC0
  assign spaceNormal = fc[1] ^ fc[0];
  // FC = 7 is CPU space
  assign spaceCpu = (fc == 3'd7);

  // Decode only during an address strobe
  assign normalCycle = !nAS && spaceNormal;
  assign cpuCycle = !nAS && spaceCpu;

  assign dramHit = normalCycle && (addr[31:30] == `SYSCTL_DRAM_TAG);
  // Bank 0 stands in for ROM while the reset vectors are fetched
  assign overlayHit = dramHit && (addr[29:28] == 2'd0) && resetVecFetch;
  assign romHit = (normalCycle && (addr[31:20] == `SYSCTL_ROM_TAG)) || overlayHit;

  // ROM output enable only makes sense for reads
  assign nRomSel = !(romHit && rnW);

  assign nDevSpace = !(normalCycle && (addr[31:20] == `SYSCTL_DEV_TAG));
  assign nMmioSel = !(normalCycle && (addr[31:30] == `SYSCTL_MMIO_TAG));

  // Bank from addr[29:28]
  always_comb begin
    dramOneHot = '0;
    if (dramHit && !overlayHit)
      dramOneHot[addr[29:28]] = 1'b1;
  end

  assign nDramSel = ~dramOneHot;

  // Coprocessor access to the FPU
  assign nFpuSel = !(cpuCycle && (addr[19:13] == `SYSCTL_FPU_ID));
  // Interrupt acknowledge cycle
  assign nIackSel = !(cpuCycle && (addr[19:16] == `SYSCTL_IACK_TYPE));

  // No caching of boot code or peripheral registers
  assign ci = resetVecFetch || !nDevSpace;

  // Checked at the end of each bus cycle, while the address is still valid
  oneRegion: assert property (@(posedge nAS)
    $onehot0({!nRomSel, !nDevSpace, !nMmioSel, ~nDramSel, !nFpuSel, !nIackSel}));

endmodule

`default_nettype wire

// File: logic/busCycleMonitor.sv
`default_nettype none

`include "sysCtl_defs.svh"

module busCycleMonitor (
  input  wire  CPU_CLK,
  input  wire  nRST,
  input  wire  nAS,
  output logic resetVecFetch,
  output logic berr
);

  logic nAsPrev;
  logic [1:0] bootCount;
  logic [5:0] stuckCount;

  // Boot overlay
  // A bus cycle counts once its nAS is seen going high again
  always_ff @(posedge CPU_CLK or negedge nRST) begin
    if (!nRST) begin
      nAsPrev <= 1'b1;
      bootCount <= 2'd0;
      resetVecFetch <= 1'b1;
    end else begin
      nAsPrev <= nAS;
      if (nAS && !nAsPrev && bootCount != `SYSCTL_BOOT_CYCLES) begin
        bootCount <= bootCount + 2'd1;
        // Overlay ends with the last boot cycle
        if (bootCount == `SYSCTL_BOOT_CYCLES - 2'd1)
          resetVecFetch <= 1'b0;
      end
    end
  end

  // Bus-error timeout
  // Idle bus keeps the counter at zero, saturates at the limit
  always_ff @(posedge CPU_CLK or negedge nRST) begin
    if (!nRST)
      stuckCount <= 6'd0;
    else if (nAS)
      stuckCount <= 6'd0;
    else if (stuckCount != `SYSCTL_BERR_LIMIT)
      stuckCount <= stuckCount + 6'd1;
  end

  assign berr = (stuckCount == `SYSCTL_BERR_LIMIT);

  // Timeout only ever follows a cycle with nAS held low
  berrNeedsCycle: assert property (@(posedge CPU_CLK) disable iff (!nRST)
    berr |-> !$past(nAS));

endmodule

`default_nettype wire

// File: logic/sysCtlPkg.sv
`default_nettype none

package sysCtlPkg;

  // CPU bus fields
  typedef logic [31:0] addr_t;
  typedef logic [2:0] fc_t;
  typedef logic [1:0] siz_t;
  typedef logic [1:0] dsack_t;

  // Active-low lane and bank selects
  typedef logic [3:0] byteEn_t;
  typedef logic [3:0] dramSel_t;

  // I/O cycle sequencer
  typedef enum logic [3:0] {
    Idle,
    ByteWait,
    WordWait,
    TmrRd1,
    TmrRw2,
    TmrRw3,
    TmrRw4,
    TmrRec1,
    TmrRec2,
    TmrRec3,
    Finish
  } ioState_t;

endpackage

`default_nettype wire

// File: include/sysCtl_defs.svh
`ifndef SYSCTL_DEFS_SVH
`define SYSCTL_DEFS_SVH

// Top-level region tags
// ROM at $FFF0.0000, 1MB, addr[31:20]
`define SYSCTL_ROM_TAG      12'hfff
// On-board peripheral space at $FFE0.0000, addr[31:20]
`define SYSCTL_DEV_TAG      12'hffe
// 1GB of memory-mapped I/O at $8000.0000, addr[31:30]
`define SYSCTL_MMIO_TAG     2'b10
// Four 256MB DRAM banks from $0000.0000, addr[31:30]
`define SYSCTL_DRAM_TAG     2'b00
// Fast RAM at $FF80.0000, 4MB, addr[31:22]
`define SYSCTL_FRAM_TAG     10'b1111111110

// Device offsets inside device space, addr[19:4]
`define SYSCTL_DEV_DUART    16'h0000
`define SYSCTL_DEV_TMR      16'h0001
`define SYSCTL_DEV_ATA      16'h0002
`define SYSCTL_DEV_I2C      16'h0010
`define SYSCTL_DEV_INTC     16'hffff

// CPU space, addr[19:13]
// Access type 2 (coprocessor) with coprocessor ID 1
`define SYSCTL_FPU_ID       7'b0010001
// Interrupt acknowledge access type, addr[19:16]
`define SYSCTL_IACK_TYPE    4'hf

// Clocks without termination before berr
`define SYSCTL_BERR_LIMIT   6'd63
// Bus cycles covered by the boot overlay
`define SYSCTL_BOOT_CYCLES  2'd3

// DSACK encodings
`define SYSCTL_PORT8        2'b01
`define SYSCTL_PORT16       2'b10

`endif
